//--- filelist.f
hw/arch_pkg.sv
hw/op_pkg.sv
hw/issue_if.sv
hw/wb_if.sv
hw/issue_stage.sv
hw/scoreboard.sv
hw/exec_pipe.sv
hw/reg_file.sv
hw/issue_core.sv
tb/tb_issue_core.sv

//--- Makefile
TOP = tb_issue_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_issue_core.sv
`timescale 1ns/100ps

module tb_issue_core;

   localparam int EXEC_DEPTH   = 3;
   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_BUNDLES  = 400;
   localparam int LANES        = arch_pkg::NUM_LANES;

   logic                             clkrst_core_clk;
   logic                             clkrst_core_rst_n;
   logic                             bundle_valid;
   op_pkg::op_t        [LANES-1:0]   slot_op;
   arch_pkg::reg_num_t [LANES-1:0]   slot_rs1;
   arch_pkg::reg_num_t [LANES-1:0]   slot_rs2;
   arch_pkg::reg_num_t [LANES-1:0]   slot_rd_num;
   logic               [LANES-1:0]   slot_rd_we;
   logic               [LANES-1:0]   slot_pred_we;
   logic                             stall;
   arch_pkg::reg_num_t [LANES-1:0]   wb_rd_num;
   logic               [LANES-1:0]   wb_rd_we;
   logic               [LANES-1:0]   wb_pred_we;
   arch_pkg::data_t    [LANES-1:0]   wb_data;
   arch_pkg::reg_mask_t              reg_busy;
   arch_pkg::pred_mask_t             pred_busy;
   arch_pkg::pred_mask_t             preds;

   // reference model.
   arch_pkg::data_t      model_regs [arch_pkg::NUM_REGS];
   arch_pkg::pred_mask_t model_preds;
   arch_pkg::reg_mask_t  model_reg_busy;
   arch_pkg::pred_mask_t model_pred_busy;

   // accepted bundles waiting for writeback.
   int                             due_q     [$];
   arch_pkg::data_t    [LANES-1:0] data_q    [$];
   arch_pkg::reg_num_t [LANES-1:0] rd_num_q  [$];
   logic               [LANES-1:0] rd_we_q   [$];
   logic               [LANES-1:0] pred_we_q [$];

   logic                           wb_fire;  // writeback seen this cycle lands at the next edge.
   arch_pkg::data_t    [LANES-1:0] fire_data;
   arch_pkg::reg_num_t [LANES-1:0] fire_rd_num;
   logic               [LANES-1:0] fire_rd_we;
   logic               [LANES-1:0] fire_pred_we;

   integer seed;
   int     cycle;
   int     n_gen;
   int     idle;
   logic   pending;
   logic   accept_next;
   logic   took;

   issue_core #(
      .EXEC_DEPTH (EXEC_DEPTH)
   ) dut_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .slot_op           (slot_op),
      .slot_rs1          (slot_rs1),
      .slot_rs2          (slot_rs2),
      .slot_rd_num       (slot_rd_num),
      .slot_rd_we        (slot_rd_we),
      .slot_pred_we      (slot_pred_we),
      .stall             (stall),
      .wb_rd_num         (wb_rd_num),
      .wb_rd_we          (wb_rd_we),
      .wb_pred_we        (wb_pred_we),
      .wb_data           (wb_data),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy),
      .preds             (preds)
   );

   initial begin
      clkrst_core_clk = 1'b0;
      forever #(CLK_PERIOD / 2) clkrst_core_clk = ~clkrst_core_clk;
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                                 $time, name, got, exp));
      end
   endtask

   function automatic arch_pkg::data_t lane_result(input op_pkg::op_t op,
                                                   input arch_pkg::data_t a,
                                                   input arch_pkg::data_t b);
      case (op)
         op_pkg::OP_ADD:  return a + b;
         op_pkg::OP_SUB:  return a - b;
         op_pkg::OP_XOR:  return a ^ b;
         op_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
         default:         return '0;
      endcase
   endfunction

   // hazard rule on the driven bundle against the model masks.
   function automatic logic bundle_hazard();
      logic hit;
      hit = 1'b0;
      for (int l = 0; l < LANES; l++) begin
         if (model_reg_busy[slot_rs1[l]] || model_reg_busy[slot_rs2[l]]) begin
            hit = 1'b1;
         end
         if (slot_rd_we[l] && model_reg_busy[slot_rd_num[l]]) begin
            hit = 1'b1;
         end
         if (slot_pred_we[l] && slot_rd_num[l] < 5'd3 &&
             model_pred_busy[slot_rd_num[l][1:0]]) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   task automatic make_bundle();
      arch_pkg::reg_mask_t used;
      arch_pkg::reg_num_t  cand;
      logic [31:0]         r;
      used = '0;
      for (int l = 0; l < LANES; l++) begin
         r = $random(seed);
         slot_op[l]  = r[1:0];
         slot_rs1[l] = {2'b00, r[4:2]};  // narrow range, frequent hazards.
         slot_rs2[l] = {2'b00, r[7:5]};
         cand = r[8] ? {3'b000, r[10:9]} : {1'b0, r[14:11]};
         while (used[cand]) begin
            r = $random(seed);
            cand = {1'b0, r[3:0]};
         end
         used[cand]      = 1'b1;
         slot_rd_num[l]  = cand;
         slot_rd_we[l]   = r[17] | r[18];
         slot_pred_we[l] = (cand < 5'd3) && r[19];
      end
   endtask

   task automatic drive_next();
      logic [31:0] r;
      if (took) begin
         pending = 1'b0;  // accepted at this edge.
      end
      if (clkrst_core_rst_n && !pending && n_gen < NUM_BUNDLES) begin
         r = $random(seed);
         if (r % 32'd10 < 32'd8) begin
            make_bundle();
            pending = 1'b1;
            n_gen++;
         end
      end
      bundle_valid = pending;
   endtask

   task automatic model_edge();
      arch_pkg::reg_mask_t         clr_reg;
      arch_pkg::pred_mask_t        clr_pred;
      arch_pkg::reg_mask_t         set_reg;
      arch_pkg::pred_mask_t        set_pred;
      arch_pkg::data_t [LANES-1:0] res;
      clr_reg     = '0;
      clr_pred    = '0;
      set_reg     = '0;
      set_pred    = '0;
      took        = accept_next;
      accept_next = 1'b0;
      if (took) begin
         // operands are read before this edge's writeback lands.
         for (int l = 0; l < LANES; l++) begin
            res[l] = lane_result(slot_op[l], model_regs[slot_rs1[l]], model_regs[slot_rs2[l]]);
            if (slot_rd_we[l]) begin
               set_reg[slot_rd_num[l]] = 1'b1;
            end
            if (slot_pred_we[l]) begin
               set_pred[slot_rd_num[l][1:0]] = 1'b1;
            end
         end
         due_q.push_back(cycle + EXEC_DEPTH);
         data_q.push_back(res);
         rd_num_q.push_back(slot_rd_num);
         rd_we_q.push_back(slot_rd_we);
         pred_we_q.push_back(slot_pred_we);
      end
      if (wb_fire) begin
         for (int l = 0; l < LANES; l++) begin
            if (fire_rd_we[l]) begin
               model_regs[fire_rd_num[l]] = fire_data[l];
               clr_reg[fire_rd_num[l]] = 1'b1;
            end
            if (fire_pred_we[l]) begin
               model_preds[fire_rd_num[l][1:0]] = fire_data[l][0];
               clr_pred[fire_rd_num[l][1:0]] = 1'b1;
            end
         end
      end
      wb_fire         = 1'b0;
      model_reg_busy  = (model_reg_busy | set_reg) & ~clr_reg;  // clear wins.
      model_pred_busy = (model_pred_busy | set_pred) & ~clr_pred;
   endtask

   task automatic check_cycle();
      logic exp_stall;
      exp_stall = bundle_valid && bundle_hazard();
      compare("stall", 128'(stall), 128'(exp_stall));
      compare("reg_busy", 128'(reg_busy), 128'(model_reg_busy));
      compare("pred_busy", 128'(pred_busy), 128'(model_pred_busy));
      compare("preds", 128'(preds), 128'(model_preds));
      if (due_q.size() > 0 && due_q[0] == cycle) begin
         compare("wb_rd_we", 128'(wb_rd_we), 128'(rd_we_q[0]));
         compare("wb_pred_we", 128'(wb_pred_we), 128'(pred_we_q[0]));
         compare("wb_rd_num", 128'(wb_rd_num), 128'(rd_num_q[0]));
         compare("wb_data", 128'(wb_data), 128'(data_q[0]));
         void'(due_q.pop_front());
         fire_data    = data_q.pop_front();
         fire_rd_num  = rd_num_q.pop_front();
         fire_rd_we   = rd_we_q.pop_front();
         fire_pred_we = pred_we_q.pop_front();
         wb_fire      = 1'b1;
      end else begin
         compare("wb_rd_we", 128'(wb_rd_we), 128'(0));
         compare("wb_pred_we", 128'(wb_pred_we), 128'(0));
      end
      accept_next = bundle_valid && !exp_stall;
   endtask

   initial begin
      #(NUM_BUNDLES * 20 * CLK_PERIOD);
      stop_on_error("watchdog expired before all bundles were written back");
   end

   initial begin
      seed              = 32'hf9d55330;
      clkrst_core_rst_n = 1'b0;
      bundle_valid      = 1'b0;
      slot_op           = '0;
      slot_rs1          = '0;
      slot_rs2          = '0;
      slot_rd_num       = '0;
      slot_rd_we        = '0;
      slot_pred_we      = '0;
      for (int r = 0; r < arch_pkg::NUM_REGS; r++) begin
         model_regs[r] = '0;
      end
      model_preds     = '0;
      model_reg_busy  = '0;
      model_pred_busy = '0;
      wb_fire         = 1'b0;
      cycle           = 0;
      n_gen           = 0;
      idle            = 0;
      pending         = 1'b0;
      accept_next     = 1'b0;
      took            = 1'b0;
      while (idle < 4) begin
         @(posedge clkrst_core_clk);
         cycle++;
         model_edge();
         #1;
         if (cycle == RESET_CYCLES) begin
            clkrst_core_rst_n = 1'b1;
         end
         drive_next();
         @(negedge clkrst_core_clk);
         check_cycle();
         if (n_gen == NUM_BUNDLES && !pending && due_q.size() == 0 && !wb_fire) begin
            idle++;  // quiet cycles after the drain.
         end
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

//--- hw/issue_core.sv
`timescale 1ns/100ps

module issue_core #(
   parameter int EXEC_DEPTH = 3
) (
   input  logic                                         clkrst_core_clk,
   input  logic                                         clkrst_core_rst_n,
   input  logic                                         bundle_valid,
   input  op_pkg::op_t        [arch_pkg::NUM_LANES-1:0] slot_op,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] slot_rs1,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] slot_rs2,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] slot_rd_num,
   input  logic               [arch_pkg::NUM_LANES-1:0] slot_rd_we,
   input  logic               [arch_pkg::NUM_LANES-1:0] slot_pred_we,
   output logic                                         stall,
   output arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] wb_rd_num,
   output logic               [arch_pkg::NUM_LANES-1:0] wb_rd_we,
   output logic               [arch_pkg::NUM_LANES-1:0] wb_pred_we,
   output arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] wb_data,
   output arch_pkg::reg_mask_t                          reg_busy,
   output arch_pkg::pred_mask_t                         pred_busy,
   output arch_pkg::pred_mask_t                         preds
);

   arch_pkg::reg_num_t [arch_pkg::NUM_RD_PORTS-1:0] rf_rd_num;
   arch_pkg::data_t    [arch_pkg::NUM_RD_PORTS-1:0] rf_rd_data;

   issue_if iss_bus ();
   wb_if    wb_bus ();

   issue_stage issue_stage_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .slot_op           (slot_op),
      .slot_rs1          (slot_rs1),
      .slot_rs2          (slot_rs2),
      .slot_rd_num       (slot_rd_num),
      .slot_rd_we        (slot_rd_we),
      .slot_pred_we      (slot_pred_we),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy),
      .rf_rd_num         (rf_rd_num),
      .rf_rd_data        (rf_rd_data),
      .stall             (stall),
      .iss               (iss_bus.src)
   );

   scoreboard scoreboard_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .iss               (iss_bus.dst),
      .wb                (wb_bus.dst),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy)
   );

   exec_pipe #(
      .EXEC_DEPTH (EXEC_DEPTH)
   ) exec_pipe_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .iss               (iss_bus.dst),
      .wb                (wb_bus.src)
   );

   reg_file reg_file_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .rd_num            (rf_rd_num),
      .rd_data           (rf_rd_data),
      .wb                (wb_bus.dst),
      .preds             (preds)
   );

   assign wb_rd_num  = wb_bus.rd_num;
   assign wb_rd_we   = wb_bus.rd_we;
   assign wb_pred_we = wb_bus.pred_we;
   assign wb_data    = wb_bus.data;

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

module reg_file (
   input  logic                                            clkrst_core_clk,
   input  logic                                            clkrst_core_rst_n,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_RD_PORTS-1:0] rd_num,
   output arch_pkg::data_t    [arch_pkg::NUM_RD_PORTS-1:0] rd_data,
   wb_if.dst                                               wb,
   output arch_pkg::pred_mask_t                            preds
);

   arch_pkg::data_t regs [arch_pkg::NUM_REGS];

   always_comb begin
      for (int p = 0; p < arch_pkg::NUM_RD_PORTS; p++) begin
         rd_data[p] = regs[rd_num[p]];  // no write-through.
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int r = 0; r < arch_pkg::NUM_REGS; r++) begin
            regs[r] <= '0;
         end
         preds <= '0;
      end else begin
         for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
            if (wb.rd_we[l]) begin
               regs[wb.rd_num[l]] <= wb.data[l];
            end
            // predicate takes bit 0 of the lane result.
            for (int p = 0; p < arch_pkg::NUM_PREDS; p++) begin
               if (wb.pred_we[l] && wb.rd_num[l] == arch_pkg::reg_num_t'(p)) begin
                  preds[p] <= wb.data[l][0];
               end
            end
         end
      end
   end

   // no two lanes may target one register in the same cycle.
   for (genvar i = 0; i < arch_pkg::NUM_LANES; i++) begin : g_wr_a
      for (genvar j = i + 1; j < arch_pkg::NUM_LANES; j++) begin : g_wr_b
         a_no_dup_write: assert property (
            @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
            !(wb.rd_we[i] && wb.rd_we[j] && wb.rd_num[i] == wb.rd_num[j])
         );
      end
   end

endmodule

//--- hw/exec_pipe.sv
`timescale 1ns/100ps

module exec_pipe #(
   parameter int EXEC_DEPTH = 3
) (
   input logic  clkrst_core_clk,
   input logic  clkrst_core_rst_n,
   issue_if.dst iss,
   wb_if.src    wb
);

   arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] result;

   arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] st_data    [EXEC_DEPTH];
   arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] st_rd_num  [EXEC_DEPTH];
   logic               [arch_pkg::NUM_LANES-1:0] st_rd_we   [EXEC_DEPTH];
   logic               [arch_pkg::NUM_LANES-1:0] st_pred_we [EXEC_DEPTH];

   always_comb begin
      for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
         case (iss.op[l])
            op_pkg::OP_ADD: result[l] = iss.a[l] + iss.b[l];
            op_pkg::OP_SUB: result[l] = iss.a[l] - iss.b[l];
            op_pkg::OP_XOR: result[l] = iss.a[l] ^ iss.b[l];
            default:        result[l] = arch_pkg::data_t'(iss.a[l] < iss.b[l]);  // OP_SLTU.
         endcase
      end
   end

   // write enables only live while a bundle is issued.
   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int s = 0; s < EXEC_DEPTH; s++) begin
            st_rd_we[s]   <= '0;
            st_pred_we[s] <= '0;
         end
      end else begin
         st_rd_we[0]   <= iss.rd_we & {arch_pkg::NUM_LANES{iss.progress}};
         st_pred_we[0] <= iss.pred_we & {arch_pkg::NUM_LANES{iss.progress}};
         for (int s = 1; s < EXEC_DEPTH; s++) begin
            st_rd_we[s]   <= st_rd_we[s-1];
            st_pred_we[s] <= st_pred_we[s-1];
         end
      end
   end

   always_ff @(posedge clkrst_core_clk) begin
      st_data[0]   <= result;
      st_rd_num[0] <= iss.rd_num;
      for (int s = 1; s < EXEC_DEPTH; s++) begin
         st_data[s]   <= st_data[s-1];
         st_rd_num[s] <= st_rd_num[s-1];
      end
   end

   // last stage is the writeback register.
   assign wb.data    = st_data[EXEC_DEPTH-1];
   assign wb.rd_num  = st_rd_num[EXEC_DEPTH-1];
   assign wb.rd_we   = st_rd_we[EXEC_DEPTH-1];
   assign wb.pred_we = st_pred_we[EXEC_DEPTH-1];

endmodule

//--- hw/scoreboard.sv
`timescale 1ns/100ps

module scoreboard (
   input  logic                 clkrst_core_clk,
   input  logic                 clkrst_core_rst_n,
   issue_if.dst                 iss,
   wb_if.dst                    wb,
   output arch_pkg::reg_mask_t  reg_busy,
   output arch_pkg::pred_mask_t pred_busy
);

   arch_pkg::reg_mask_t  reg_set;
   arch_pkg::reg_mask_t  reg_clr;
   arch_pkg::reg_mask_t  reg_busy_q;
   arch_pkg::pred_mask_t pred_set;
   arch_pkg::pred_mask_t pred_clr;
   arch_pkg::pred_mask_t pred_busy_q;

   always_comb begin
      reg_set  = '0;
      reg_clr  = '0;
      pred_set = '0;
      pred_clr = '0;
      for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
         if (iss.progress && iss.rd_we[l]) begin
            reg_set[iss.rd_num[l]] = 1'b1;
         end
         if (wb.rd_we[l]) begin
            reg_clr[wb.rd_num[l]] = 1'b1;
         end
         for (int p = 0; p < arch_pkg::NUM_PREDS; p++) begin
            if (iss.progress && iss.pred_we[l] && iss.rd_num[l] == arch_pkg::reg_num_t'(p)) begin
               pred_set[p] = 1'b1;
            end
            if (wb.pred_we[l] && wb.rd_num[l] == arch_pkg::reg_num_t'(p)) begin
               pred_clr[p] = 1'b1;
            end
         end
      end
   end

   // clear applied last so it wins over a same-cycle set.
   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         reg_busy_q  <= '0;
         pred_busy_q <= '0;
      end else begin
         reg_busy_q  <= (reg_busy_q | reg_set) & ~reg_clr;
         pred_busy_q <= (pred_busy_q | pred_set) & ~pred_clr;
      end
   end

   // a bundle owns its destinations from the edge that accepted it.
   assign reg_busy  = reg_busy_q | reg_set;
   assign pred_busy = pred_busy_q | pred_set;

   for (genvar l = 0; l < arch_pkg::NUM_LANES; l++) begin : g_pred_range
      a_pred_num_range: assert property (
         @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
         iss.progress && iss.pred_we[l] |-> int'(iss.rd_num[l]) < arch_pkg::NUM_PREDS
      );
   end

   // issue stage holds any bundle whose destination is still owned.
   a_set_only_free: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      (reg_set & reg_busy_q) == '0 && (pred_set & pred_busy_q) == '0
   );

endmodule

//--- hw/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
   input  logic                                            clkrst_core_clk,
   input  logic                                            clkrst_core_rst_n,
   input  logic                                            bundle_valid,
   input  op_pkg::op_t        [arch_pkg::NUM_LANES-1:0]    slot_op,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0]    slot_rs1,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0]    slot_rs2,
   input  arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0]    slot_rd_num,
   input  logic               [arch_pkg::NUM_LANES-1:0]    slot_rd_we,
   input  logic               [arch_pkg::NUM_LANES-1:0]    slot_pred_we,
   input  arch_pkg::reg_mask_t                             reg_busy,
   input  arch_pkg::pred_mask_t                            pred_busy,
   output arch_pkg::reg_num_t [arch_pkg::NUM_RD_PORTS-1:0] rf_rd_num,
   input  arch_pkg::data_t    [arch_pkg::NUM_RD_PORTS-1:0] rf_rd_data,
   output logic                                            stall,
   issue_if.src                                            iss
);

   logic [arch_pkg::NUM_LANES-1:0] lane_hazard;
   logic                           accept;

   // port 2l reads rs1 of lane l, port 2l+1 reads rs2.
   always_comb begin
      for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
         rf_rd_num[2*l]   = slot_rs1[l];
         rf_rd_num[2*l+1] = slot_rs2[l];
      end
   end

   // no bypass, so any busy source waits for its writeback.
   always_comb begin
      for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
         lane_hazard[l] = reg_busy[slot_rs1[l]] | reg_busy[slot_rs2[l]]
                        | (slot_rd_we[l] & reg_busy[slot_rd_num[l]]);
         for (int p = 0; p < arch_pkg::NUM_PREDS; p++) begin
            if (slot_pred_we[l] && slot_rd_num[l] == arch_pkg::reg_num_t'(p) &&
                pred_busy[p]) begin
               lane_hazard[l] = 1'b1;
            end
         end
      end
   end

   assign stall  = bundle_valid & (|lane_hazard);
   assign accept = bundle_valid & ~stall;

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         iss.progress <= 1'b0;
      end else begin
         iss.progress <= accept;  // one cycle per bundle.
      end
   end

   always_ff @(posedge clkrst_core_clk) begin
      if (accept) begin
         iss.op      <= slot_op;
         iss.rd_num  <= slot_rd_num;
         iss.rd_we   <= slot_rd_we;
         iss.pred_we <= slot_pred_we;
         for (int l = 0; l < arch_pkg::NUM_LANES; l++) begin
            iss.a[l] <= rf_rd_data[2*l];
            iss.b[l] <= rf_rd_data[2*l+1];
         end
      end
   end

   // a stalled bundle is held steady by its source.
   a_hold_on_stall: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      bundle_valid && stall |=> bundle_valid && $stable(slot_op) && $stable(slot_rs1) &&
                                $stable(slot_rs2) && $stable(slot_rd_num) &&
                                $stable(slot_rd_we) && $stable(slot_pred_we)
   );

endmodule

//--- hw/wb_if.sv
`timescale 1ns/100ps

// writeback lanes, execute pipe to register file and scoreboard.
interface wb_if;

   arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] rd_num;
   logic               [arch_pkg::NUM_LANES-1:0] rd_we;
   logic               [arch_pkg::NUM_LANES-1:0] pred_we;
   arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] data;

   modport src (
      output rd_num,
      output rd_we,
      output pred_we,
      output data
   );

   modport dst (
      input rd_num,
      input rd_we,
      input pred_we,
      input data
   );

endinterface

//--- hw/issue_if.sv
`timescale 1ns/100ps

// issued bundle with operands, issue stage to execute and scoreboard.
interface issue_if;

   logic                                         progress;  // bundle present this cycle.
   op_pkg::op_t        [arch_pkg::NUM_LANES-1:0] op;
   arch_pkg::reg_num_t [arch_pkg::NUM_LANES-1:0] rd_num;
   logic               [arch_pkg::NUM_LANES-1:0] rd_we;
   logic               [arch_pkg::NUM_LANES-1:0] pred_we;
   arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] a;
   arch_pkg::data_t    [arch_pkg::NUM_LANES-1:0] b;

   modport src (
      output progress,
      output op,
      output rd_num,
      output rd_we,
      output pred_we,
      output a,
      output b
   );

   modport dst (
      input progress,
      input op,
      input rd_num,
      input rd_we,
      input pred_we,
      input a,
      input b
   );

endinterface

//--- hw/op_pkg.sv
package op_pkg;

   // slot opcode field.
   typedef logic [1:0] op_t;

   // a + b.
   localparam op_t OP_ADD = 2'd0;

   // a - b.
   localparam op_t OP_SUB = 2'd1;

   // bitwise a ^ b.
   localparam op_t OP_XOR = 2'd2;

   // 1 when a < b as unsigned values, else 0.
   localparam op_t OP_SLTU = 2'd3;

endpackage

//--- hw/arch_pkg.sv
package arch_pkg;

   // register file geometry.
   localparam int REG_NUM_W = 5;
   localparam int DATA_W    = 32;
   localparam int NUM_REGS  = 1 << REG_NUM_W;

   // bundle shape, fixed since port widths follow it.
   localparam int NUM_LANES    = 4;
   localparam int NUM_RD_PORTS = 2 * NUM_LANES;  // two sources per lane.

   localparam int NUM_PREDS = 3;

   // register number as carried in a slot.
   typedef logic [REG_NUM_W-1:0] reg_num_t;

   // register value and lane result.
   typedef logic [DATA_W-1:0] data_t;

   // one busy bit per general register.
   typedef logic [NUM_REGS-1:0] reg_mask_t;

   // one bit per predicate register.
   typedef logic [NUM_PREDS-1:0] pred_mask_t;

endpackage
